// ==== common/cpu_pkg.sv ====
/*
  shared types for the three stage integer core
  instruction fields, opcode and funct codes, alu operations
*/

package cpu_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // basic widths

   typedef logic [31:0] word_t;     // data word
   typedef logic [4:0]  regbits_t;  // register index

   ////////////////////////////////////////////////////////////////////////////
   // major opcodes, kept subset only

   typedef enum logic [5:0] {
      RTYPE = 6'b000000,
      ADDIU = 6'b001001,
      SLTI  = 6'b001010,
      SLTIU = 6'b001011,
      ANDI  = 6'b001100,
      ORI   = 6'b001101,
      XORI  = 6'b001110,
      LUI   = 6'b001111,
      HALT  = 6'b111111   // stop, no write
   } opcode_t;

   // r-type function codes
   typedef enum logic [5:0] {
      SLL  = 6'b000000,
      SRL  = 6'b000010,
      ADDU = 6'b100001,
      SUBU = 6'b100011,
      AND  = 6'b100100,
      OR   = 6'b100101,
      XOR  = 6'b100110,
      NOR  = 6'b100111,
      SLT  = 6'b101010,
      SLTU = 6'b101011
   } funct_t;

   ////////////////////////////////////////////////////////////////////////////
   // execute side codes

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOR,
      ALU_SLT,    // signed compare
      ALU_SLTU,   // unsigned compare
      ALU_SLL,
      ALU_SRL
   } aluop_t;

   typedef enum logic [1:0] {
      SRC_REG,    // rt register
      SRC_IMM,    // extended immediate
      SRC_SHAMT   // shift by instruction shamt
   } alusrc_t;

   // instruction formats
   typedef struct packed {
      opcode_t  opcode;
      regbits_t rs;
      regbits_t rt;
      regbits_t rd;
      logic [4:0] shamt;
      funct_t   funct;
   } r_t;

   typedef struct packed {
      opcode_t  opcode;
      regbits_t rs;
      regbits_t rt;
      logic [15:0] imm;
   } i_t;

   // one word, two views
   typedef union packed {
      r_t r;
      i_t i;
   } instr_u;

endpackage

// ==== decode/control_unit.sv ====
/*
  decode table for the kept instruction subset
*/

module control_unit import cpu_pkg::*; (
   input  opcode_t opcode_i,
   input  funct_t  funct_i,
   output aluop_t  aluop_o,
   output alusrc_t alusrc_o,
   output logic    sign_ext_o,
   output logic    rtype_dest_o,
   output logic    reg_write_o,
   output logic    halt_o
);

   always_comb begin
      // defaults give a no-op that writes nothing
      aluop_o      = ALU_ADD;
      alusrc_o     = SRC_REG;
      sign_ext_o   = 1'b0;
      rtype_dest_o = 1'b0;
      reg_write_o  = 1'b0;
      halt_o       = 1'b0;

      case (opcode_i)
         RTYPE: begin
            rtype_dest_o = 1'b1;
            reg_write_o  = 1'b1;
            case (funct_i)
               ADDU: aluop_o = ALU_ADD;
               SUBU: aluop_o = ALU_SUB;
               AND:  aluop_o = ALU_AND;
               OR:   aluop_o = ALU_OR;
               XOR:  aluop_o = ALU_XOR;
               NOR:  aluop_o = ALU_NOR;
               SLT:  aluop_o = ALU_SLT;
               SLTU: aluop_o = ALU_SLTU;
               SLL: begin
                  aluop_o  = ALU_SLL;
                  alusrc_o = SRC_SHAMT;
               end
               SRL: begin
                  aluop_o  = ALU_SRL;
                  alusrc_o = SRC_SHAMT;
               end
               default: reg_write_o = 1'b0;  // unknown funct, drop
            endcase
         end
         ADDIU, SLTI, SLTIU: begin
            alusrc_o    = SRC_IMM;
            sign_ext_o  = 1'b1;              // sltiu too, compare is unsigned
            reg_write_o = 1'b1;
            if (opcode_i == SLTI)       aluop_o = ALU_SLT;
            else if (opcode_i == SLTIU) aluop_o = ALU_SLTU;
         end
         ANDI, ORI, XORI: begin
            alusrc_o    = SRC_IMM;           // zero extended
            reg_write_o = 1'b1;
            if (opcode_i == ANDI)      aluop_o = ALU_AND;
            else if (opcode_i == ORI)  aluop_o = ALU_OR;
            else                       aluop_o = ALU_XOR;
         end
         LUI: begin
            aluop_o     = ALU_SLL;           // imm << 16 in the alu
            alusrc_o    = SRC_IMM;
            reg_write_o = 1'b1;
         end
         HALT: halt_o = 1'b1;
         default: ;                          // unknown opcode, no-op
      endcase
   end

endmodule

// ==== decode/decode_stage.sv ====
/*
  decode stage: accepts instruction words, reads registers,
  extends the immediate and loads the id/ex register
*/

module decode_stage import cpu_pkg::*; (
   input  logic       CLK,
   input  logic       nRST,
   input  logic       inst_valid_i,
   input  instr_u     inst_i,
   output logic       inst_ready_o,
   output regbits_t   rsel1_o,
   output regbits_t   rsel2_o,
   input  word_t      rdat1_i,
   input  word_t      rdat2_i,
   output logic       ex_valid_o,
   output aluop_t     ex_aluop_o,
   output alusrc_t    ex_alusrc_o,
   output regbits_t   ex_rs_o,
   output regbits_t   ex_rt_o,
   output word_t      ex_a_o,
   output word_t      ex_b_o,
   output word_t      ex_imm_o,
   output logic [4:0] ex_shamt_o,
   output regbits_t   ex_dest_o,
   output logic       ex_wen_o,
   output logic       ex_halt_o
);

   aluop_t   aluop;
   alusrc_t  alusrc;
   logic     sign_ext, rtype_dest, reg_write, halt;
   logic     accept, locked;
   word_t    imm_ext;
   regbits_t dest;

   control_unit i_control (
      .opcode_i (inst_i.r.opcode), .funct_i (inst_i.r.funct),
      .aluop_o (aluop), .alusrc_o (alusrc),
      .sign_ext_o (sign_ext), .rtype_dest_o (rtype_dest),
      .reg_write_o (reg_write), .halt_o (halt)
   );

   assign inst_ready_o = !locked;                 // low for good after halt
   assign accept       = inst_valid_i && inst_ready_o;

   // register reads straight off the incoming word
   assign rsel1_o = inst_i.r.rs;
   assign rsel2_o = inst_i.i.rt;

   assign imm_ext = sign_ext ? {{16{inst_i.i.imm[15]}}, inst_i.i.imm}
                             : {16'h0000, inst_i.i.imm};
   assign dest    = rtype_dest ? inst_i.r.rd : inst_i.i.rt;

   ////////////////////////////////////////////////////////////////////////////
   // halt lock-out and id/ex control

   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         locked     <= 1'b0;
         ex_valid_o <= 1'b0;
         ex_wen_o   <= 1'b0;
         ex_halt_o  <= 1'b0;
      end else begin
         locked     <= locked || (accept && halt);
         ex_valid_o <= accept;                    // bubble when nothing taken
         ex_wen_o   <= accept && reg_write && (dest != '0);  // r0 never written
         ex_halt_o  <= accept && halt;
      end
   end

   // id/ex payload, qualified by valid downstream
   always_ff @(posedge CLK) begin
      ex_aluop_o  <= aluop;
      ex_alusrc_o <= alusrc;
      ex_rs_o     <= inst_i.r.rs;
      ex_rt_o     <= inst_i.i.rt;
      ex_a_o      <= rdat1_i;
      ex_b_o      <= rdat2_i;
      ex_imm_o    <= imm_ext;
      ex_shamt_o  <= inst_i.r.shamt;
      ex_dest_o   <= dest;
   end

endmodule

// ==== execute/alu.sv ====
/*
  alu: add, sub, logic ops, set-less-than and logical shifts
*/

module alu import cpu_pkg::*; (
   input  word_t      a_i,
   input  word_t      b_i,
   input  logic [4:0] shamt_i,
   input  aluop_t     op_i,
   output word_t      result_o
);

   logic lt_signed, lt_unsigned;

   assign lt_signed   = $signed(a_i) < $signed(b_i);
   assign lt_unsigned = a_i < b_i;

   always_comb begin
      case (op_i)
         ALU_ADD:  result_o = a_i + b_i;      // wraps, no overflow trap
         ALU_SUB:  result_o = a_i - b_i;
         ALU_AND:  result_o = a_i & b_i;
         ALU_OR:   result_o = a_i | b_i;
         ALU_XOR:  result_o = a_i ^ b_i;
         ALU_NOR:  result_o = ~(a_i | b_i);
         ALU_SLT:  result_o = {31'b0, lt_signed};
         ALU_SLTU: result_o = {31'b0, lt_unsigned};
         // shifts move operand b, as rt in sll/srl
         ALU_SLL:  result_o = b_i << shamt_i;
         ALU_SRL:  result_o = b_i >> shamt_i;
         default:  result_o = '0;
      endcase
   end

endmodule

// ==== execute/execute_stage.sv ====
/*
  execute stage: forwarding from ex/wb, operand select, alu,
  the ex/wb register with commit outputs and the sticky halt flag
*/

module execute_stage import cpu_pkg::*; (
   input  logic       CLK,
   input  logic       nRST,
   input  logic       ex_valid_i,
   input  aluop_t     ex_aluop_i,
   input  alusrc_t    ex_alusrc_i,
   input  regbits_t   ex_rs_i,
   input  regbits_t   ex_rt_i,
   input  word_t      ex_a_i,
   input  word_t      ex_b_i,
   input  word_t      ex_imm_i,
   input  logic [4:0] ex_shamt_i,
   input  regbits_t   ex_dest_i,
   input  logic       ex_wen_i,
   input  logic       ex_halt_i,
   output logic       commit_valid_o,
   output regbits_t   commit_sel_o,
   output word_t      commit_data_o,
   output logic       halt_o
);

   logic       wb_valid, wb_wen;
   word_t      fwd_a, fwd_b, alu_b, alu_out;
   logic [4:0] alu_shamt;

   ////////////////////////////////////////////////////////////////////////////
   // forwarding, one instruction back only

   // two back is covered by the register file bypass
   assign fwd_a = (commit_valid_o && commit_sel_o == ex_rs_i) ? commit_data_o : ex_a_i;
   assign fwd_b = (commit_valid_o && commit_sel_o == ex_rt_i) ? commit_data_o : ex_b_i;

   // second operand and shift amount
   always_comb begin
      case (ex_alusrc_i)
         SRC_IMM: begin
            alu_b     = ex_imm_i;
            alu_shamt = 5'd16;      // lui moves imm to the upper half
         end
         SRC_SHAMT: begin
            alu_b     = fwd_b;
            alu_shamt = ex_shamt_i;
         end
         default: begin
            alu_b     = fwd_b;
            alu_shamt = 5'd16;
         end
      endcase
   end

   alu i_alu (
      .a_i (fwd_a), .b_i (alu_b), .shamt_i (alu_shamt),
      .op_i (ex_aluop_i), .result_o (alu_out)
   );

   ////////////////////////////////////////////////////////////////////////////
   // ex/wb register

   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         wb_valid <= 1'b0;
         wb_wen   <= 1'b0;
         halt_o   <= 1'b0;
      end else begin
         wb_valid <= ex_valid_i;
         wb_wen   <= ex_wen_i;
         halt_o   <= halt_o || (ex_valid_i && ex_halt_i);   // sticky
      end
   end

   always_ff @(posedge CLK) begin
      commit_sel_o  <= ex_dest_i;
      commit_data_o <= alu_out;
   end

   assign commit_valid_o = wb_valid && wb_wen;

   // halt stays up until reset
   a_halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
      halt_o |=> halt_o)
      else $error("halt flag dropped");

   // decode lock-out must have drained the pipe by the time halt shows
   a_no_commit_after_halt: assert property (@(posedge CLK) disable iff (!nRST)
      halt_o |-> !commit_valid_o)
      else $error("commit seen after halt");

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_mips_core \
   -Mdir obj_dir -f sim.f

# the simulator exit code is not trusted, the log decides
./obj_dir/Vtb_mips_core > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation completed successfully$" sim.log; then
   exit 0
fi
exit 1

// ==== sim.f ====
common/cpu_pkg.sv
src/register_file.sv
decode/control_unit.sv
decode/decode_stage.sv
execute/alu.sv
execute/execute_stage.sv
src/mips_core.sv
tb/tb_clock.sv
tb/tb_mips_core.sv

// ==== src/mips_core.sv ====
/*
  three stage integer core: decode, execute, write back
  instruction words come straight in, results go out on commit
*/

module mips_core import cpu_pkg::*; (
   input  logic     CLK,
   input  logic     nRST,
   input  logic     inst_valid_i,
   input  word_t    inst_i,
   output logic     inst_ready_o,
   output logic     commit_valid_o,
   output regbits_t commit_sel_o,
   output word_t    commit_data_o,
   output logic     halt_o
);

   // register file read side
   regbits_t rsel1, rsel2;
   word_t    rdat1, rdat2;

   // id/ex register
   logic     ex_valid, ex_wen, ex_halt;
   aluop_t   ex_aluop;
   alusrc_t  ex_alusrc;
   regbits_t ex_rs, ex_rt, ex_dest;
   word_t    ex_a, ex_b, ex_imm;
   logic [4:0] ex_shamt;

   ////////////////////////////////////////////////////////////////////////////
   // stages

   decode_stage i_decode (
      .CLK, .nRST,
      .inst_valid_i, .inst_i, .inst_ready_o,
      .rsel1_o (rsel1), .rsel2_o (rsel2),
      .rdat1_i (rdat1), .rdat2_i (rdat2),
      .ex_valid_o (ex_valid), .ex_aluop_o (ex_aluop), .ex_alusrc_o (ex_alusrc),
      .ex_rs_o (ex_rs), .ex_rt_o (ex_rt),
      .ex_a_o (ex_a), .ex_b_o (ex_b), .ex_imm_o (ex_imm), .ex_shamt_o (ex_shamt),
      .ex_dest_o (ex_dest), .ex_wen_o (ex_wen), .ex_halt_o (ex_halt)
   );

   // write port fed from the commit outputs
   register_file i_regfile (
      .CLK, .nRST,
      .rsel1_i (rsel1), .rsel2_i (rsel2),
      .rdat1_o (rdat1), .rdat2_o (rdat2),
      .wen_i (commit_valid_o), .wsel_i (commit_sel_o), .wdat_i (commit_data_o)
   );

   execute_stage i_execute (
      .CLK, .nRST,
      .ex_valid_i (ex_valid), .ex_aluop_i (ex_aluop), .ex_alusrc_i (ex_alusrc),
      .ex_rs_i (ex_rs), .ex_rt_i (ex_rt),
      .ex_a_i (ex_a), .ex_b_i (ex_b), .ex_imm_i (ex_imm), .ex_shamt_i (ex_shamt),
      .ex_dest_i (ex_dest), .ex_wen_i (ex_wen), .ex_halt_i (ex_halt),
      .commit_valid_o, .commit_sel_o, .commit_data_o, .halt_o
   );

endmodule

// ==== src/register_file.sv ====
/*
  register file, 31 writable registers plus hardwired zero
  two read ports, write data bypassed to a matching read
*/

module register_file import cpu_pkg::*; (
   input  logic     CLK,
   input  logic     nRST,
   input  regbits_t rsel1_i,
   input  regbits_t rsel2_i,
   output word_t    rdat1_o,
   output word_t    rdat2_o,
   input  logic     wen_i,
   input  regbits_t wsel_i,
   input  word_t    wdat_i
);

   word_t regs [1:31];  // r0 not stored

   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         for (int k = 1; k < 32; k++) begin
            regs[k] <= '0;
         end
      end else if (wen_i && wsel_i != '0) begin
         regs[wsel_i] <= wdat_i;
      end
   end

   // read port 1
   always_comb begin
      if (rsel1_i == '0)                   rdat1_o = '0;   // zero register
      else if (wen_i && wsel_i == rsel1_i) rdat1_o = wdat_i;  // same cycle bypass
      else                                 rdat1_o = regs[rsel1_i];
   end

   // read port 2
   always_comb begin
      if (rsel2_i == '0)                   rdat2_o = '0;
      else if (wen_i && wsel_i == rsel2_i) rdat2_o = wdat_i;
      else                                 rdat2_o = regs[rsel2_i];
   end

   // decode drops writes to r0 before they reach write back
   a_no_r0_write: assert property (@(posedge CLK) disable iff (!nRST)
      wen_i |-> wsel_i != '0)
      else $error("register file write aimed at r0");

endmodule

// ==== tb/tb_clock.sv ====
/*
  testbench clock and reset, period 100, reset low for two cycles
*/

module tb_clock (
   output logic CLK,
   output logic nRST
);

   localparam int PERIOD = 100;

   initial begin
      CLK = 1'b0;
      forever #(PERIOD / 2) CLK = ~CLK;
   end

   // released on a falling edge, clear of the rising ones
   initial begin
      nRST = 1'b0;
      #(2 * PERIOD) nRST = 1'b1;
   end

endmodule

// ==== tb/tb_mips_core.sv ====
/*
  testbench for the three stage core
  directed and random alu stream against an in-order model followed by halt
*/

module tb_mips_core import cpu_pkg::*;;

   localparam int N_DIRECTED = 10;
   localparam int N_SLOTS    = 400;                     // issue slots for about 300 instructions
   localparam int N_TAIL     = 6;                       // cycles watched after halt
   localparam int WATCHDOG   = (N_SLOTS + 1 + N_TAIL + 20) * 100;

   logic     CLK, nRST;
   logic     inst_valid_i, inst_ready_o;
   word_t    inst_i;
   logic     commit_valid_o, halt_o;
   regbits_t commit_sel_o;
   word_t    commit_data_o;

   word_t    model_regs [32];
   regbits_t exp_sel_q [$];                             // expected commits in order
   word_t    exp_dat_q [$];
   logic     locked;                                    // model of decode lock-out
   logic     due1, due2;                                // commit due one / two samples on
   logic     hlt1, hlt2, exp_halt;
   word_t    directed [N_DIRECTED];

   tb_clock i_clock (.CLK, .nRST);

   mips_core i_mips_core (
      .CLK, .nRST, .inst_valid_i, .inst_i, .inst_ready_o,
      .commit_valid_o, .commit_sel_o, .commit_data_o, .halt_o
   );

   ////////////////////////////////////////////////////////////////////////////
   // failure reporting and compare tasks

   task automatic report_error(input string msg);
      $display("ERR %0t: %s", $time, msg);
      $display("Simulation failed");
      $fatal(1, "stopped at first mismatch");
   endtask

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "run aborted");
   endtask

   task automatic check_commit(input regbits_t sel, input word_t dat);
      if (commit_valid_o !== 1'b1 || commit_sel_o !== sel || commit_data_o !== dat)
         report_error($sformatf("commit r%0d=%h valid %b, expected r%0d=%h",
            commit_sel_o, commit_data_o, commit_valid_o, sel, dat));
   endtask

   task automatic check_commit_valid(input logic exp);
      if (commit_valid_o !== exp)
         report_error($sformatf("commit_valid_o is %b, expected %b", commit_valid_o, exp));
   endtask

   task automatic check_halt(input logic exp);
      if (halt_o !== exp)
         report_error($sformatf("halt_o is %b, expected %b", halt_o, exp));
   endtask

   task automatic check_ready(input logic exp);
      if (inst_ready_o !== exp)
         report_error($sformatf("inst_ready_o is %b, expected %b", inst_ready_o, exp));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // instruction words

   function automatic word_t encode_r(funct_t fn, regbits_t rs, regbits_t rt,
                                      regbits_t rd, logic [4:0] sh);
      return {RTYPE, rs, rt, rd, sh, fn};
   endfunction

   function automatic word_t encode_i(opcode_t op, regbits_t rs, regbits_t rt,
                                      logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic regbits_t random_reg();
      if ($urandom_range(0, 9) < 8)
         return regbits_t'($urandom_range(0, 7));       // mostly r0..r7 for dense deps
      return regbits_t'($urandom_range(0, 31));
   endfunction

   function automatic word_t random_instr();
      int unsigned kind;
      regbits_t    rs, rt, rd;
      logic [15:0] imm;
      kind = $urandom_range(0, 16);
      rs   = random_reg();
      rt   = random_reg();
      rd   = random_reg();
      imm  = 16'($urandom());                           // half of them negative
      case (kind)
         0:  return encode_r(ADDU, rs, rt, rd, 5'd0);
         1:  return encode_r(SUBU, rs, rt, rd, 5'd0);
         2:  return encode_r(AND, rs, rt, rd, 5'd0);
         3:  return encode_r(OR, rs, rt, rd, 5'd0);
         4:  return encode_r(XOR, rs, rt, rd, 5'd0);
         5:  return encode_r(NOR, rs, rt, rd, 5'd0);
         6:  return encode_r(SLT, rs, rt, rd, 5'd0);
         7:  return encode_r(SLTU, rs, rt, rd, 5'd0);
         8:  return encode_r(SLL, 5'd0, rt, rd, 5'($urandom()));
         9:  return encode_r(SRL, 5'd0, rt, rd, 5'($urandom()));
         10: return encode_i(ADDIU, rs, rt, imm);
         11: return encode_i(ANDI, rs, rt, imm);
         12: return encode_i(ORI, rs, rt, imm);
         13: return encode_i(XORI, rs, rt, imm);
         14: return encode_i(SLTI, rs, rt, imm);
         15: return encode_i(SLTIU, rs, rt, imm);
         default: return encode_i(LUI, 5'd0, rt, imm);
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // reference model stepping one instruction at a time in program order

   task automatic model_step(input word_t w, output logic wr, output regbits_t dest,
                             output word_t res);
      word_t a, b, sext, zext;
      a    = model_regs[w[25:21]];                      // r0 always reads zero
      b    = model_regs[w[20:16]];
      sext = {{16{w[15]}}, w[15:0]};
      zext = {16'h0000, w[15:0]};
      wr   = 1'b1;
      dest = w[20:16];                                  // rt for i-type
      res  = '0;
      case (w[31:26])
         RTYPE: begin
            dest = w[15:11];
            case (w[5:0])
               ADDU: res = a + b;
               SUBU: res = a - b;
               AND:  res = a & b;
               OR:   res = a | b;
               XOR:  res = a ^ b;
               NOR:  res = ~(a | b);
               SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               SLTU: res = (a < b) ? 32'd1 : 32'd0;
               SLL:  res = b << w[10:6];
               SRL:  res = b >> w[10:6];
               default: wr = 1'b0;
            endcase
         end
         ADDIU: res = a + sext;
         ANDI:  res = a & zext;
         ORI:   res = a | zext;
         XORI:  res = a ^ zext;
         SLTI:  res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
         SLTIU: res = (a < sext) ? 32'd1 : 32'd0;   // sign extended imm with unsigned compare
         LUI:   res = {w[15:0], 16'h0000};
         default: wr = 1'b0;                            // halt writes nothing
      endcase
      if (dest == '0)
         wr = 1'b0;
      if (wr)
         model_regs[dest] = res;
   endtask

   // falling edge compare of outputs and log of what the next rising edge takes
   task automatic sample_cycle();
      logic     wr;
      regbits_t dest;
      word_t    res;
      check_ready(!locked);
      if (due2)
         check_commit(exp_sel_q.pop_front(), exp_dat_q.pop_front());
      else
         check_commit_valid(1'b0);
      if (halt_o === 1'b1 && !exp_halt && exp_sel_q.size() != 0)
         report_failure($sformatf("halt rose with %0d results still outstanding",
            exp_sel_q.size()));
      exp_halt = exp_halt | hlt2;                       // sticky
      check_halt(exp_halt);
      due2 = due1;
      hlt2 = hlt1;
      due1 = 1'b0;
      hlt1 = 1'b0;
      if (inst_valid_i && !locked) begin
         model_step(inst_i, wr, dest, res);
         if (wr) begin
            exp_sel_q.push_back(dest);
            exp_dat_q.push_back(res);
            due1 = 1'b1;
         end
         if (inst_i[31:26] == HALT) begin
            hlt1   = 1'b1;
            locked = 1'b1;
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // stimulus

   initial begin : stimulus
      void'($urandom(32'he8c7278a));
      inst_valid_i <= 1'b0;
      inst_i       <= '0;
      for (int r = 0; r < 32; r++)
         model_regs[r] = '0;
      locked   = 1'b0;
      due1     = 1'b0;
      due2     = 1'b0;
      hlt1     = 1'b0;
      hlt2     = 1'b0;
      exp_halt = 1'b0;
      // lui, shifts and slti against sltiu on negative immediates
      directed[0] = encode_i(LUI, 5'd0, 5'd1, 16'h8001);
      directed[1] = encode_i(ORI, 5'd1, 5'd1, 16'h00ff);     // one back forward
      directed[2] = encode_r(SLL, 5'd0, 5'd1, 5'd2, 5'd4);
      directed[3] = encode_r(SRL, 5'd0, 5'd1, 5'd3, 5'd31);  // two back
      directed[4] = encode_i(SLTI, 5'd0, 5'd4, 16'hffff);
      directed[5] = encode_i(SLTIU, 5'd0, 5'd5, 16'hffff);
      directed[6] = encode_i(SLTI, 5'd1, 5'd6, 16'h8000);
      directed[7] = encode_i(SLTIU, 5'd1, 5'd7, 16'h8000);
      directed[8] = encode_r(ADDU, 5'd1, 5'd2, 5'd0, 5'd0);  // r0 target never commits
      directed[9] = encode_i(ADDIU, 5'd0, 5'd2, 16'hfffe);

      wait (nRST === 1'b1);
      @(negedge CLK);
      check_ready(1'b1);                                // idle after reset
      check_commit_valid(1'b0);
      check_halt(1'b0);

      for (int s = 0; s < N_SLOTS; s++) begin
         @(posedge CLK);
         if (s < N_DIRECTED) begin
            inst_valid_i <= 1'b1;
            inst_i       <= directed[s];
         end else begin
            inst_valid_i <= ($urandom_range(0, 3) != 0);  // ~3/4 busy
            inst_i       <= random_instr();
         end
         @(negedge CLK);
         sample_cycle();
      end

      // halt followed by words that must be refused
      @(posedge CLK);
      inst_valid_i <= 1'b1;
      inst_i       <= {HALT, 26'h0};
      @(negedge CLK);
      sample_cycle();
      for (int t = 0; t < N_TAIL; t++) begin
         @(posedge CLK);
         inst_i <= random_instr();
         @(negedge CLK);
         sample_cycle();
      end

      $display("Simulation completed successfully");
      $finish;
   end

   // watchdog sized from the slot count, the halt and the tail
   initial begin : watchdog
      #(WATCHDOG);
      $display("timeout, the run did not finish within %0d time units", WATCHDOG);
      $display("Simulation failed");
      $fatal(1, "watchdog expired");
   end

endmodule
